// File: hdl/icache_access_if.sv
// icache access bundle
// latched fetch address, lookup strobes and way choices
`timescale 1ns/1ps

interface icache_access_if
    import icache_pkg::*;
();

    logic [ADDR_W-1:0] req_addr;
    logic              look;
    logic              hit;
    logic              hit_way;
    logic              victim_way;
    logic              touch;
    logic              touch_way;
    logic              fill;

    modport ctrl (
        output req_addr, look, touch, touch_way, fill,
        input  hit, hit_way, victim_way
    );

    modport lookup (
        input  req_addr, look, touch, touch_way, fill,
        output hit, hit_way, victim_way
    );

    modport respond (
        input req_addr, look, hit, hit_way, fill
    );

endinterface

// File: hdl/icache_lookup.sv
// icache lookup
// tag compare of both ways, per-set ages and victim choice
`timescale 1ns/1ps

module icache_lookup
    import icache_pkg::*;
#(
    parameter int  NUM_SETS = 64,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = ADDR_W - OFFS_W - IDX_W
) (
    input  logic             clk,
    input  logic             rst,
    icache_access_if.lookup  acc,
    input  logic             i_req_accept,
    input  logic [TAG_W-1:0] i_tag0,
    input  logic             i_valid0,
    input  logic [TAG_W-1:0] i_tag1,
    input  logic             i_valid1
);

    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    logic [AGE_W-1:0] age_q [NUM_WAYS][NUM_SETS];

    logic [IDX_W-1:0] set_idx;
    logic [TAG_W-1:0] req_tag;
    logic             match0;
    logic             match1;
    logic [AGE_W-1:0] age0;
    logic [AGE_W-1:0] age1;
    logic             victim;
    logic             clr_en;
    logic             clr_way;

    assign set_idx = acc.req_addr[OFFS_W +: IDX_W];
    assign req_tag = acc.req_addr[ADDR_W-1 -: TAG_W];

    assign match0 = i_valid0 && (i_tag0 == req_tag);
    assign match1 = i_valid1 && (i_tag1 == req_tag);

    assign acc.hit     = acc.look && (match0 || match1);
    // way 0 answers if both were ever to match
    assign acc.hit_way = !match0 && match1;

    assign age0 = age_q[0][set_idx];
    assign age1 = age_q[1][set_idx];

    // empty way first, then the older one, ties to way 0
    always_comb begin
        if (!i_valid0) begin
            victim = 1'b0;
        end else if (!i_valid1) begin
            victim = 1'b1;
        end else begin
            victim = (age1 > age0);
        end
    end

    assign acc.victim_way = victim;

    assign clr_en  = acc.touch || acc.fill;
    assign clr_way = acc.touch ? acc.touch_way : victim;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    age_q[w][s] <= '0;
                end
            end
        end else begin
            // every accepted fetch ages all lines
            if (i_req_accept) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    for (int s = 0; s < NUM_SETS; s++) begin
                        if (age_q[w][s] != AGE_MAX) begin
                            age_q[w][s] <= age_q[w][s] + 1'b1;
                        end
                    end
                end
            end
            // later assignment, so the clear wins
            if (clr_en) begin
                age_q[clr_way][set_idx] <= '0;
            end
        end
    end

endmodule

// File: hdl/icache_pkg.sv
// icache shared definitions
// widths, field positions and refill sequencer states
package icache_pkg;

    // core and memory widths
    localparam int ADDR_W = 64;
    localparam int INST_W = 32;
    localparam int LINE_W = 64;

    // byte offset inside one line
    localparam int OFFS_W = 3;

    // picks the upper or lower instruction of a line
    localparam int INST_SEL_BIT = 2;

    // saturating age counters, one per way and set
    localparam int AGE_W = 3;

    // the lookup and the victim logic are written for two ways
    localparam int NUM_WAYS = 2;

    // refill sequencer
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOOKUP = 2'd1,
        MISS   = 2'd2,
        FILL   = 2'd3
    } refill_state_t;

endpackage

// File: hdl/icache_refill_ctrl.sv
// icache refill sequencer
// lookup, miss request and line fill flow, RAM index and write enables
`timescale 1ns/1ps

module icache_refill_ctrl
    import icache_pkg::*;
#(
    parameter int  NUM_SETS = 64,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_req,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic              i_mem_ok,
    icache_access_if.ctrl     acc,
    output logic              o_req_accept,
    output logic [IDX_W-1:0]  o_index,
    output logic              o_we0,
    output logic              o_we1,
    output logic              o_busy,
    output logic              o_mem_rd,
    output logic [ADDR_W-1:0] o_mem_addr
);

    refill_state_t     state_q;
    refill_state_t     state_d;
    logic [ADDR_W-1:0] addr_q;
    logic              mem_wait;
    logic              mem_done;

    assign o_req_accept = (state_q == IDLE) && i_req;

    // MISS is the first cycle of the read, FILL the rest of the wait
    assign mem_wait = (state_q == MISS) || (state_q == FILL);
    assign mem_done = mem_wait && i_mem_ok;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_req) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = acc.hit ? IDLE : MISS;
            end
            MISS: begin
                state_d = i_mem_ok ? IDLE : FILL;
            end
            FILL: begin
                if (i_mem_ok) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
            addr_q  <= '0;
        end else begin
            state_q <= state_d;
            if (o_req_accept) begin
                addr_q <= i_addr;
            end
        end
    end

    // live address starts the read on the accepting edge
    assign o_index = (state_q == IDLE) ? i_addr[OFFS_W +: IDX_W] : addr_q[OFFS_W +: IDX_W];

    assign acc.req_addr  = addr_q;
    assign acc.look      = (state_q == LOOKUP);
    assign acc.touch     = acc.look && acc.hit;
    assign acc.touch_way = acc.hit_way;
    assign acc.fill      = mem_done;

    assign o_we0 = mem_done && !acc.victim_way;
    assign o_we1 = mem_done && acc.victim_way;

    assign o_busy     = (state_q != IDLE);
    assign o_mem_rd   = mem_wait;
    assign o_mem_addr = {addr_q[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};

endmodule

// File: hdl/icache_respond.sv
// icache responder
// registered instruction from the hit way or from the refill line
`timescale 1ns/1ps

module icache_respond
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    icache_access_if.respond  acc,
    input  logic [LINE_W-1:0] i_line0,
    input  logic [LINE_W-1:0] i_line1,
    input  logic              i_mem_ok,
    input  logic [LINE_W-1:0] i_mem_data,
    output logic              o_valid,
    output logic [INST_W-1:0] o_data
);

    logic              take_hit;
    logic              take_any;
    logic [LINE_W-1:0] hit_line;
    logic [LINE_W-1:0] src_line;
    logic [INST_W-1:0] word;

    assign take_hit = acc.look && acc.hit;
    assign take_any = take_hit || acc.fill;

    assign hit_line = acc.hit_way ? i_line1 : i_line0;
    // memory only answers during a refill
    assign src_line = i_mem_ok ? i_mem_data : hit_line;

    assign word = acc.req_addr[INST_SEL_BIT] ? src_line[LINE_W-1 -: INST_W]
                                             : src_line[INST_W-1:0];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= take_any;
        end
    end

    always_ff @(posedge clk) begin
        if (take_any) begin
            o_data <= word;
        end
    end

endmodule

// File: hdl/icache_top.sv
// two-way instruction cache
// ways, lookup, refill sequencer and responder behind plain core and memory ports
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
#(
    parameter int  NUM_SETS = 64,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = ADDR_W - OFFS_W - IDX_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_req,
    input  logic [ADDR_W-1:0] i_addr,
    output logic              o_busy,
    output logic              o_valid,
    output logic [INST_W-1:0] o_data,
    output logic              o_mem_rd,
    output logic [ADDR_W-1:0] o_mem_addr,
    input  logic              i_mem_ok,
    input  logic [LINE_W-1:0] i_mem_data
);

    icache_access_if acc ();

    logic              req_accept;
    logic [IDX_W-1:0]  ram_index;
    logic              we0;
    logic              we1;
    logic [TAG_W-1:0]  fill_tag;
    logic [TAG_W-1:0]  tag0;
    logic [TAG_W-1:0]  tag1;
    logic              valid0;
    logic              valid1;
    logic [LINE_W-1:0] line0;
    logic [LINE_W-1:0] line1;

    assign fill_tag = acc.req_addr[ADDR_W-1 -: TAG_W];

    icache_way_ram #(.NUM_SETS(NUM_SETS)) u_way0 (
        .clk(clk), .rst(rst), .i_index(ram_index), .i_we(we0),
        .i_tag(fill_tag), .i_line(i_mem_data),
        .o_tag(tag0), .o_valid_bit(valid0), .o_line(line0)
    );

    icache_way_ram #(.NUM_SETS(NUM_SETS)) u_way1 (
        .clk(clk), .rst(rst), .i_index(ram_index), .i_we(we1),
        .i_tag(fill_tag), .i_line(i_mem_data),
        .o_tag(tag1), .o_valid_bit(valid1), .o_line(line1)
    );

    icache_lookup #(.NUM_SETS(NUM_SETS)) u_lookup (
        .clk(clk), .rst(rst), .acc(acc.lookup), .i_req_accept(req_accept),
        .i_tag0(tag0), .i_valid0(valid0), .i_tag1(tag1), .i_valid1(valid1)
    );

    icache_refill_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl (
        .clk(clk), .rst(rst), .i_req(i_req), .i_addr(i_addr), .i_mem_ok(i_mem_ok),
        .acc(acc.ctrl), .o_req_accept(req_accept), .o_index(ram_index),
        .o_we0(we0), .o_we1(we1), .o_busy(o_busy),
        .o_mem_rd(o_mem_rd), .o_mem_addr(o_mem_addr)
    );

    icache_respond u_respond (
        .clk(clk), .rst(rst), .acc(acc.respond), .i_line0(line0), .i_line1(line1),
        .i_mem_ok(i_mem_ok), .i_mem_data(i_mem_data),
        .o_valid(o_valid), .o_data(o_data)
    );

endmodule

// File: hdl/icache_way_ram.sv
// icache way storage
// tag, valid bit and line per set, registered read and single write
`timescale 1ns/1ps

module icache_way_ram
    import icache_pkg::*;
#(
    parameter int  NUM_SETS = 64,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = ADDR_W - OFFS_W - IDX_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [IDX_W-1:0]  i_index,
    input  logic              i_we,
    input  logic [TAG_W-1:0]  i_tag,
    input  logic [LINE_W-1:0] i_line,
    output logic [TAG_W-1:0]  o_tag,
    output logic              o_valid_bit,
    output logic [LINE_W-1:0] o_line
);

    logic [TAG_W-1:0]  tag_mem  [NUM_SETS];
    logic [LINE_W-1:0] line_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    // arrays, read and write share one index
    always_ff @(posedge clk) begin
        if (i_we) begin
            tag_mem[i_index]  <= i_tag;
            line_mem[i_index] <= i_line;
        end
        o_tag  <= tag_mem[i_index];
        o_line <= line_mem[i_index];
    end

    // valid bits need a known state after reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q     <= '0;
            o_valid_bit <= 1'b0;
        end else begin
            if (i_we) begin
                valid_q[i_index] <= 1'b1;
            end
            o_valid_bit <= valid_q[i_index];
        end
    end

endmodule

// File: icache.f
hdl/icache_pkg.sv
hdl/icache_access_if.sv
hdl/icache_way_ram.sv
hdl/icache_lookup.sv
hdl/icache_refill_ctrl.sv
hdl/icache_respond.sv
hdl/icache_top.sv
tb/icache_tb.sv

// File: tb/icache_tb.sv
// icache testbench
// LFSR fetches against a reference cache model and a delayed memory model
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
;

    localparam int NUM_SETS = 64;
    localparam int IDX_W    = $clog2(NUM_SETS);
    localparam int TAG_W    = ADDR_W - OFFS_W - IDX_W;
    localparam int NUM_REQ  = 400;
    localparam int AGE_TOP  = (1 << AGE_W) - 1;

    logic              clk;
    logic              rst;
    logic              i_req;
    logic [ADDR_W-1:0] i_addr;
    logic              o_busy;
    logic              o_valid;
    logic [INST_W-1:0] o_data;
    logic              o_mem_rd;
    logic [ADDR_W-1:0] o_mem_addr;
    logic              i_mem_ok;
    logic [LINE_W-1:0] i_mem_data;

    logic [31:0]       lfsr = 32'hbf548877;
    int                checks;
    int                value_errs;
    int                proto_errs;
    int                valid_pulses;
    logic              ok_at_edge;
    logic              rd_prev;
    logic [ADDR_W-1:0] addr_prev;

    // reference model state
    logic [TAG_W-1:0]  m_tag   [NUM_SETS][NUM_WAYS];
    logic              m_valid [NUM_SETS][NUM_WAYS];
    int                m_age   [NUM_SETS][NUM_WAYS];

    icache_top #(.NUM_SETS(NUM_SETS)) UUT (
        .clk(clk), .rst(rst), .i_req(i_req), .i_addr(i_addr),
        .o_busy(o_busy), .o_valid(o_valid), .o_data(o_data),
        .o_mem_rd(o_mem_rd), .o_mem_addr(o_mem_addr),
        .i_mem_ok(i_mem_ok), .i_mem_data(i_mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // memory contents as a fixed mix of line address bits
    function automatic logic [LINE_W-1:0] line_of(input logic [ADDR_W-1:0] la);
        line_of = {la[31:0] ^ 32'hc3a5_0f96,
                   la[63:32] ^ {la[15:0], la[31:16]} ^ 32'h1b2d_4e87};
    endfunction

    // four tags in each of four sets make sets overflow often
    function automatic logic [ADDR_W-1:0] addr_of(input logic [4:0] r);
        logic [TAG_W-1:0] t;
        logic [IDX_W-1:0] s;
        case (r[1:0])
            2'd0: s = IDX_W'(5);
            2'd1: s = IDX_W'(17);
            2'd2: s = IDX_W'(40);
            default: s = IDX_W'(63);
        endcase
        case (r[3:2])
            2'd0: t = TAG_W'(64'h0);
            2'd1: t = TAG_W'(64'h1);
            2'd2: t = TAG_W'(64'h3a_5c01);
            default: t = TAG_W'(64'h7f_0000_1234_55);
        endcase
        addr_of = {t, s, r[4], 2'b00};
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            value_errs++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // ages first, then hit or victim, then clear the used way
    task automatic model_access(input logic [ADDR_W-1:0] a, output bit hit);
        int               s;
        int               way;
        logic [TAG_W-1:0] t;
        s   = a[OFFS_W +: IDX_W];
        t   = a[ADDR_W-1 -: TAG_W];
        hit = 1'b0;
        way = 0;
        foreach (m_age[i, j]) begin
            if (m_age[i][j] < AGE_TOP) begin
                m_age[i][j]++;
            end
        end
        if (m_valid[s][0] && m_tag[s][0] == t) begin
            hit = 1'b1;
        end else if (m_valid[s][1] && m_tag[s][1] == t) begin
            hit = 1'b1;
            way = 1;
        end else begin
            if (!m_valid[s][0]) begin
                way = 0;
            end else if (!m_valid[s][1]) begin
                way = 1;
            end else begin
                way = (m_age[s][1] > m_age[s][0]) ? 1 : 0;
            end
            m_tag[s][way]   = t;
            m_valid[s][way] = 1'b1;
        end
        m_age[s][way] = 0;
    endtask

    // one fetch that enters and leaves on a falling edge
    task automatic fetch(input logic [ADDR_W-1:0] a);
        bit                exp_hit;
        logic [31:0]       delay;
        logic [ADDR_W-1:0] la;
        logic [LINE_W-1:0] line;
        logic [INST_W-1:0] exp_word;
        la       = {a[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
        line     = line_of(la);
        exp_word = a[INST_SEL_BIT] ? line[63:32] : line[31:0];
        i_req  = 1'b1;
        i_addr = a;
        model_access(a, exp_hit);
        @(negedge clk);
        i_req = 1'b0;
        compare_value("o_busy", o_busy, 1);
        compare_value("o_valid", o_valid, 0);
        compare_value("o_mem_rd", o_mem_rd, 0);
        @(negedge clk);
        if (exp_hit) begin
            compare_value("o_mem_rd", o_mem_rd, 0);
        end else begin
            compare_value("o_mem_rd", o_mem_rd, 1);
            compare_value("o_mem_addr", o_mem_addr, la);
            compare_value("o_valid", o_valid, 0);
            take_bits(3, delay);
            // stray request while busy is ignored
            i_req  = 1'b1;
            i_addr = ~a;
            for (int d = 0; d < delay; d++) begin
                @(negedge clk);
                i_req = 1'b0;
                compare_value("o_busy", o_busy, 1);
                compare_value("o_valid", o_valid, 0);
            end
            i_mem_ok   = 1'b1;
            i_mem_data = line;
            @(negedge clk);
            i_req      = 1'b0;
            i_mem_ok   = 1'b0;
            i_mem_data = '0;
            compare_value("o_mem_rd", o_mem_rd, 0);
        end
        compare_value("o_valid", o_valid, 1);
        compare_value("o_data", o_data, exp_word);
        compare_value("o_busy", o_busy, 0);
    endtask

    always @(posedge clk) begin
        ok_at_edge = i_mem_ok;
    end

    // o_valid pulses and a steady memory read until the answer
    always @(negedge clk) begin
        if (o_valid) begin
            valid_pulses++;
        end
        if (rd_prev && !ok_at_edge) begin
            assert (o_mem_rd && o_mem_addr == addr_prev) else begin
                proto_errs++;
                $display("memory read dropped or moved before the answer at %0t", $time);
            end
        end
        rd_prev   = o_mem_rd;
        addr_prev = o_mem_addr;
    end

    initial begin
        #((NUM_REQ * 20 + 5 + 20) * 8);
        $display("watchdog expired, the DUT stopped answering at %0t", $time);
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        rst        = 1'b0;
        i_req      = 1'b0;
        i_addr     = '0;
        i_mem_ok   = 1'b0;
        i_mem_data = '0;
        foreach (m_age[i, j]) begin
            m_age[i][j]   = 0;
            m_valid[i][j] = 1'b0;
            m_tag[i][j]   = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        compare_value("o_busy", o_busy, 0);
        compare_value("o_valid", o_valid, 0);
        compare_value("o_mem_rd", o_mem_rd, 0);
        compare_value("state_q", UUT.u_ctrl.state_q, IDLE);
        for (int n = 0; n < NUM_REQ; n++) begin
            take_bits(5, r);
            fetch(addr_of(r[4:0]));
        end
        repeat (3) @(negedge clk);
        assert (valid_pulses == NUM_REQ) else begin
            proto_errs++;
            $display("saw %0d o_valid pulses for %0d requests", valid_pulses, NUM_REQ);
        end
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
